// File: verilog/isaPkg.sv
package isaPkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU function selects
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_ADD     = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    // One fetched word, viewed as whatever format its opcode says
    typedef union packed {
        rTypeT       r;
        iTypeT       i;
        sTypeT       s;
        bTypeT       b;
        logic [31:0] raw;
    } instWordT;

endpackage

// File: verilog/corePkg.sv
package corePkg;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOpT;

    typedef struct packed {
        logic  regWe;
        logic  aluSrcImm;  // Second operand from immediate
        logic  memWe;
        logic  memToReg;   // Write back load data
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    // Program load port, word indexed
    typedef struct packed {
        logic               we;
        logic [IMEM_AW-1:0] addr;
        logic [31:0]        data;
    } loadT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        logic        rdWe;     // Architectural write only
        logic [4:0]  rd;
        logic [31:0] rdData;
        logic        memWe;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } retireT;

endpackage

// File: verilog/instMem.sv
`timescale 1ns/10ps

module instMem (
    input  logic             CLK,
    input  logic [31:0]      addr,
    input  corePkg::loadT    load,
    output isaPkg::instWordT inst
);
    import corePkg::*;

    logic [31:0] mem [IMEM_DEPTH];

    // Loader writes only while the core is halted
    always_ff @(posedge CLK) begin
        if (load.we) begin
            mem[load.addr] <= load.data;
        end
    end

    // Word index from the byte-addressed PC
    assign inst = mem[addr[IMEM_AW+1:2]];

endmodule

// File: verilog/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic        CLK,
    input  logic        rstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin  // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    // x0 always reads as zero
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: verilog/decoder.sv
`timescale 1ns/10ps

module decoder (
    input  isaPkg::instWordT inst,
    output corePkg::ctrlT    ctrl,
    output logic [31:0]      imm,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd
);
    import isaPkg::*;
    import corePkg::*;

    logic [6:0] opcode;
    logic       subBit;
    logic [3:0] aluKey;   // {funct7[5], funct3}
    aluOpT      functOp;

    assign opcode = inst.r.opcode;
    assign rs1    = inst.r.rs1;
    assign rs2    = inst.r.rs2;
    assign rd     = inst.r.rd;

    // Bit 30 is immediate data on I-type
    assign subBit = (opcode == OPC_RTYPE) ? inst.r.funct7[5] : 1'b0;
    assign aluKey = {subBit, inst.r.funct3};

    always_comb begin
        case (aluKey)
            {F7_ADD[5], F3_ADD_SUB}: functOp = ALU_ADD;
            {F7_SUB[5], F3_ADD_SUB}: functOp = ALU_SUB;
            {F7_ADD[5], F3_AND}:     functOp = ALU_AND;
            {F7_ADD[5], F3_OR}:      functOp = ALU_OR;
            {F7_ADD[5], F3_SLT}:     functOp = ALU_SLT;
            default:                 functOp = ALU_ADD;
        endcase
    end

    // Main control and immediate select
    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        imm        = '0;
        case (opcode)
            OPC_RTYPE: begin
                ctrl.regWe = 1'b1;
                ctrl.aluOp = functOp;
            end
            OPC_ITYPE: begin
                ctrl.regWe     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = functOp;
                imm            = {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            OPC_LOAD: begin
                ctrl.regWe     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
                imm            = {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            OPC_STORE: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWe     = 1'b1;
                imm            = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;  // Equal when difference is zero
                imm         = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                               inst.b.imm10to5, inst.b.imm4to1, 1'b0};
            end
            default: begin
                // Unknown opcode retires as a no-op
                ctrl.aluOp = ALU_ADD;
            end
        endcase
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  corePkg::aluOpT op,
    output logic [31:0]    result,
    output logic           zero
);
    import corePkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};  // Signed compare
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: verilog/dataMem.sv
`timescale 1ns/10ps

module dataMem (
    input  logic        CLK,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    import corePkg::*;

    logic [31:0]        mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordIdx;

    // Byte address low bits ignored, words only
    assign wordIdx = addr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];

endmodule

// File: verilog/pcUnit.sv
`timescale 1ns/10ps

module pcUnit (
    input  logic        CLK,
    input  logic        rstN,
    input  logic        run,
    input  logic        takeBranch,
    input  logic [31:0] imm,
    output logic [31:0] pc,
    output logic [31:0] pcNext
);

    // Branch target is PC relative
    assign pcNext = takeBranch ? (pc + imm) : (pc + 32'd4);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (run) begin  // Hold while halted
            pc <= pcNext;
        end
    end

endmodule

// File: verilog/singleCpu.sv
`timescale 1ns/10ps

module singleCpu (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            run,
    input  corePkg::loadT   progLoad,
    output corePkg::retireT retire
);
    import isaPkg::*;
    import corePkg::*;

    logic [31:0] pc;
    instWordT    inst;
    ctrlT        ctrl;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluB;
    logic [31:0] result;
    logic        zero;
    logic [31:0] memRdata;
    logic [31:0] wbData;
    logic        takeBranch;
    logic        regWe;
    logic        memWe;

    // No state changes while halted
    assign regWe      = ctrl.regWe & run;
    assign memWe      = ctrl.memWe & run;
    assign takeBranch = ctrl.branch & zero;

    assign aluB   = ctrl.aluSrcImm ? imm : rs2Data;
    assign wbData = ctrl.memToReg ? memRdata : result;

    pcUnit uPc (
        .CLK(CLK), .rstN(rstN), .run(run), .takeBranch(takeBranch),
        .imm(imm), .pc(pc), .pcNext()
    );

    instMem uImem (.CLK(CLK), .addr(pc), .load(progLoad), .inst(inst));

    decoder uDec (
        .inst(inst), .ctrl(ctrl), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    regFile uRf (
        .CLK(CLK), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd), .we(regWe),
        .wdata(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    alu uAlu (.a(rs1Data), .b(aluB), .op(ctrl.aluOp), .result(result), .zero(zero));

    dataMem uDmem (
        .CLK(CLK), .addr(result), .we(memWe), .wdata(rs2Data), .rdata(memRdata)
    );

    // Retire record for the instruction committing at the next edge
    always_comb begin
        retire.valid   = run;
        retire.pc      = pc;
        retire.inst    = inst.raw;
        retire.rdWe    = regWe && (rd != 5'd0);
        retire.rd      = rd;
        retire.rdData  = wbData;
        retire.memWe   = memWe;
        retire.memAddr = result;
        retire.memData = rs2Data;
    end

endmodule

// File: testbench/retire_properties.sv
`timescale 1ns/10ps

module retireProperties (
    input logic            CLK,
    input logic            rstN,
    input logic            takeBranch,
    input corePkg::retireT retire
);

    int failCount = 0;  // Read by the testbench at the end

    // Nothing retires while reset is held
    validLowInReset: assert property (@(posedge CLK) !rstN |-> !retire.valid)
        else begin
            $error("retire.valid high during reset");
            failCount++;
        end

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) retire.pc[1:0] == 2'b00)
        else begin
            $error("retire.pc not word aligned");
            failCount++;
        end

    // Sequential flow when no branch is taken
    pcStep: assert property (@(posedge CLK) disable iff (!rstN)
        (retire.valid && !takeBranch) |=> (retire.pc == $past(retire.pc) + 32'd4))
        else begin
            $error("retire.pc did not advance by 4");
            failCount++;
        end

endmodule

bind singleCpu retireProperties uRetireProps (
    .CLK(CLK), .rstN(rstN), .takeBranch(takeBranch), .retire(retire)
);

// File: testbench/tbSingleCpu.sv
`timescale 1ns/10ps

module tbSingleCpu;
    import isaPkg::*;
    import corePkg::*;

    logic   CLK;
    logic   rstN;
    logic   run;
    loadT   progLoad;
    retireT retire;

    int     errCount;
    int     checkCount;
    bit     timedOut;
    integer seed;

    logic [31:0] prog [$];
    logic [31:0] modelImem [IMEM_DEPTH];
    logic [31:0] modelDmem [DMEM_DEPTH];
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;

    singleCpu u_dut (.CLK(CLK), .rstN(rstN), .run(run), .progLoad(progLoad), .retire(retire));

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;  // 40 ns period

    // Instruction encoders
    function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        rWord = {f7, rs2, rs1, f3, rd, OPC_RTYPE};
    endfunction

    function automatic logic [31:0] iWord(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        iWord = {imm, rs1, (opc == OPC_LOAD) ? 3'b010 : 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] sWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        sWord = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] bWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [12:0] imm);
        bWord = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // ISA reference for the ALU functions
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  aluRef = sub ? a - b : a + b;
            3'b111:  aluRef = a & b;
            3'b110:  aluRef = a | b;
            3'b010:  aluRef = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: aluRef = a + b;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        checkCount++;
        assert (got === want) else begin
            errCount++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, want);
        end
    endtask

    // Executes one instruction on the model and forms its record
    task automatic modelStep(output retireT expRec);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] addr;
        logic [31:0] res;
        logic        wr;
        w    = modelImem[modelPc[9:2]];
        a    = modelRegs[w[19:15]];
        b    = modelRegs[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        wr   = 1'b0;
        res  = '0;
        expRec       = '0;
        expRec.valid = 1'b1;
        expRec.pc    = modelPc;
        expRec.inst  = w;
        modelPc      = modelPc + 32'd4;
        case (w[6:0])
            OPC_RTYPE: begin
                wr  = 1'b1;
                res = aluRef(w[14:12], w[30], a, b);
            end
            OPC_ITYPE: begin
                wr  = 1'b1;
                res = aluRef(w[14:12], 1'b0, a, immI);
            end
            OPC_LOAD: begin
                addr = a + immI;
                wr   = 1'b1;
                res  = modelDmem[addr[9:2]];
            end
            OPC_STORE: begin
                addr           = a + {{20{w[31]}}, w[31:25], w[11:7]};
                expRec.memWe   = 1'b1;
                expRec.memAddr = addr;
                expRec.memData = b;
                modelDmem[addr[9:2]] = b;
            end
            OPC_BRANCH: begin
                if (a == b) begin
                    modelPc = expRec.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        if (wr && (w[11:7] != 5'd0)) begin  // x0 never changes
            expRec.rdWe   = 1'b1;
            expRec.rd     = w[11:7];
            expRec.rdData = res;
            modelRegs[w[11:7]] = res;
        end
    endtask

    task automatic compareRecord(input retireT expRec);
        checkValue("retire.pc", retire.pc, expRec.pc);
        checkValue("retire.inst", retire.inst, expRec.inst);
        checkValue("retire.rdWe", retire.rdWe, expRec.rdWe);
        checkValue("retire.memWe", retire.memWe, expRec.memWe);
        if (expRec.rdWe) begin
            checkValue("retire.rd", retire.rd, expRec.rd);
            checkValue("retire.rdData", retire.rdData, expRec.rdData);
        end
        if (expRec.memWe) begin
            checkValue("retire.memAddr", retire.memAddr, expRec.memAddr);
            checkValue("retire.memData", retire.memData, expRec.memData);
        end
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            @(posedge CLK);
            progLoad.we   <= 1'b1;
            progLoad.addr <= IMEM_AW'(i);
            progLoad.data <= prog[i];
            modelImem[i] = prog[i];
        end
        @(posedge CLK);
        progLoad.we <= 1'b0;
    endtask

    task automatic pulseReset();
        @(posedge CLK);
        rstN <= 1'b0;
        repeat (10) @(posedge CLK);
        rstN <= 1'b1;
        modelPc = '0;
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
    endtask

    // Runs until n records retired, sampled mid-cycle
    task automatic runProgram(input int n);
        retireT expRec;
        int     got;
        int     cycles;
        got    = 0;
        cycles = 0;
        if (timedOut) return;
        @(posedge CLK);
        run <= 1'b1;
        while (got < n && cycles < 4 * n + 20) begin
            @(negedge CLK);
            cycles++;
            if (retire.valid === 1'b1) begin
                modelStep(expRec);
                compareRecord(expRec);
                got++;
            end
        end
        @(posedge CLK);
        run <= 1'b0;
        if (got < n) begin
            $display("Timeout: only %0d of %0d instructions retired", got, n);
            timedOut = 1'b1;
        end
    endtask

    task automatic haltAfterReset();
        prog = {};
        prog.push_back(iWord(OPC_ITYPE, 5'd1, 5'd1, 12'd1));  // Counts any halted write
        prog.push_back(iWord(OPC_ITYPE, 5'd2, 5'd1, 12'd2));
        loadProgram();
        pulseReset();
        repeat (3) begin  // Halted core retires nothing
            @(negedge CLK);
            checkValue("retire.valid", retire.valid, 32'd0);
            checkValue("retire.rdWe", retire.rdWe, 32'd0);
        end
        runProgram(2);
    endtask

    task automatic aluOperations();
        prog = {};
        prog.push_back(iWord(OPC_ITYPE, 5'd1, 5'd0, 12'd25));
        prog.push_back(iWord(OPC_ITYPE, 5'd2, 5'd0, -12'sd7));
        prog.push_back(rWord(F7_ADD, F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        prog.push_back(rWord(F7_SUB, F3_ADD_SUB, 5'd4, 5'd1, 5'd2));
        prog.push_back(rWord(F7_ADD, F3_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(rWord(F7_ADD, F3_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(rWord(F7_ADD, F3_SLT, 5'd7, 5'd2, 5'd1));  // Negative operand
        prog.push_back(rWord(F7_ADD, F3_SLT, 5'd8, 5'd1, 5'd2));
        prog.push_back(iWord(OPC_ITYPE, 5'd9, 5'd2, -12'sd100));
        loadProgram();
        pulseReset();
        runProgram(9);
    endtask

    task automatic storeThenLoad();
        prog = {};
        prog.push_back(iWord(OPC_ITYPE, 5'd1, 5'd0, 12'd64));
        prog.push_back(iWord(OPC_ITYPE, 5'd2, 5'd0, -12'sd300));
        prog.push_back(sWord(5'd2, 5'd1, 12'd8));
        prog.push_back(iWord(OPC_LOAD, 5'd3, 5'd1, 12'd8));
        prog.push_back(rWord(F7_ADD, F3_ADD_SUB, 5'd4, 5'd3, 5'd3));
        loadProgram();
        pulseReset();
        runProgram(5);
    endtask

    task automatic branchTargets();
        prog = {};
        prog.push_back(iWord(OPC_ITYPE, 5'd1, 5'd0, 12'd5));
        prog.push_back(iWord(OPC_ITYPE, 5'd2, 5'd0, 12'd5));
        prog.push_back(bWord(5'd2, 5'd1, 13'd12));  // Taken, skips two
        prog.push_back(iWord(OPC_ITYPE, 5'd3, 5'd0, 12'd1));
        prog.push_back(iWord(OPC_ITYPE, 5'd3, 5'd0, 12'd2));
        prog.push_back(bWord(5'd0, 5'd1, 13'd8));   // Not taken
        prog.push_back(iWord(OPC_ITYPE, 5'd4, 5'd0, 12'd3));
        loadProgram();
        pulseReset();
        runProgram(5);
    endtask

    task automatic zeroRegWrites();
        prog = {};
        prog.push_back(iWord(OPC_ITYPE, 5'd0, 5'd0, 12'd123));
        prog.push_back(iWord(OPC_ITYPE, 5'd1, 5'd0, 12'd77));
        prog.push_back(rWord(F7_ADD, F3_ADD_SUB, 5'd2, 5'd1, 5'd0));
        prog.push_back(rWord(F7_ADD, F3_ADD_SUB, 5'd3, 5'd0, 5'd1));
        loadProgram();
        pulseReset();
        runProgram(4);
    endtask

    task automatic randomAddChain();
        logic [11:0] imm;
        prog = {};
        for (int k = 1; k <= 6; k++) begin
            imm = $random(seed);
            prog.push_back(iWord(OPC_ITYPE, 5'(k), 5'(k - 1), imm));
        end
        for (int k = 1; k <= 6; k++) begin
            prog.push_back(rWord(F7_ADD, F3_ADD_SUB, 5'(k + 6), 5'(k), 5'(k + 5)));
        end
        loadProgram();
        pulseReset();
        runProgram(12);
    endtask

    initial begin
        rstN       = 1'b0;
        run        = 1'b0;
        progLoad   = '0;
        seed       = 32'h667;
        errCount   = 0;
        checkCount = 0;
        timedOut   = 1'b0;
        modelPc    = '0;
        repeat (10) @(posedge CLK);
        rstN <= 1'b1;

        haltAfterReset();
        aluOperations();
        storeThenLoad();
        branchTargets();
        zeroRegWrites();
        randomAddChain();

        repeat (2) @(posedge CLK);
        errCount = errCount + u_dut.uRetireProps.failCount;
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checkCount, errCount, timedOut);
        if (errCount == 0 && !timedOut) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/instMem.sv
verilog/regFile.sv
verilog/decoder.sv
verilog/alu.sv
verilog/dataMem.sv
verilog/pcUnit.sv
verilog/singleCpu.sv
testbench/retire_properties.sv
testbench/tbSingleCpu.sv
